/* common/sv39_pkg.sv */
// ----------------------------------------------------------
// Sv39 address widths, page table entry layout and the
// TLB refill, flush and lookup structures
// ----------------------------------------------------------

package sv39_pkg;

  // virtual and physical address widths
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPNW          = 44;
  localparam int unsigned ASID_W        = 16;
  localparam int unsigned PAGE_OFFSET_W = 12;

  // vpn is three 9-bit fields, vpn2 at the top
  localparam int unsigned VPN_FIELD_W   = 9;
  localparam int unsigned VPN_W         = 3 * VPN_FIELD_W;

  // default data TLB size
  localparam int unsigned TLB_ENTRIES   = 4;

  // Sv39 page table entry, 64 bits
  typedef struct packed {
    logic [9:0]      reserved;
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    logic            d;
    logic            a;
    logic            g;
    logic            u;
    logic            x;
    logic            w;
    logic            r;
    logic            v;
  } pte_t;

  // refill from the walker side
  typedef struct packed {
    logic              valid;
    logic              is_2m;
    logic              is_1g;
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    pte_t              content;
  } tlb_update_t;

  // sfence style flush, zero fields mean all
  typedef struct packed {
    logic              valid;
    logic [ASID_W-1:0] asid;
    logic [VLEN-1:0]   vaddr;
  } tlb_flush_t;

  // combinational lookup result
  typedef struct packed {
    logic hit;
    logic is_2m;
    logic is_1g;
    pte_t content;
  } tlb_lookup_t;

endpackage

/* common/lsu_pkg.sv */
// ----------------------------------------------------------
// privilege levels, exception causes and the load/store
// request and response records
// ----------------------------------------------------------

package lsu_pkg;

  import sv39_pkg::*;

  // width of tval and the cause field
  localparam int unsigned xlen = 64;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // mcause/scause encodings for data page faults
  typedef enum logic [xlen-1:0] {
    LOAD_PAGE_FAULT  = 64'd13,
    STORE_PAGE_FAULT = 64'd15
  } exc_cause_e;

  typedef struct packed {
    exc_cause_e      cause;
    logic [xlen-1:0] tval;
    logic            valid;
  } exception_t;

  // one-cycle translation request from the load/store unit
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] vaddr;
    logic            is_store;
  } lsu_req_t;

  // translated address, one cycle after the request
  typedef struct packed {
    logic            valid;
    logic [PLEN-1:0] paddr;
    exception_t      ex;
  } lsu_resp_t;

endpackage

/* tlb/tlb_plru.sv */
// ----------------------------------------------------------
// tree pseudo-LRU replacement state for the TLB entries
// ----------------------------------------------------------

module tlb_plru #(
  parameter int unsigned TLB_ENTRIES = sv39_pkg::TLB_ENTRIES
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           touch_i,
  input  logic [$clog2(TLB_ENTRIES)-1:0] touch_idx_i,
  output logic [$clog2(TLB_ENTRIES)-1:0] victim_idx_o
);

  localparam int unsigned IDX_W = $clog2(TLB_ENTRIES);
  localparam int unsigned NODES = TLB_ENTRIES - 1;

  // heap ordered tree, root at 0, children of n at 2n+1 and 2n+2
  // a node bit of 0 points the victim search to the left subtree
  logic [NODES-1:0] tree_d;
  logic [NODES-1:0] tree_q;

  // walk the touched entry's path and point every node away from it
  always_comb begin : touch_update
    int unsigned node;
    node   = 0;
    tree_d = tree_q;
    for (int unsigned lvl = 0; lvl < IDX_W; lvl++) begin
      // node on level lvl is selected by the upper lvl index bits
      node = (1 << lvl) - 1 + (touch_idx_i >> (IDX_W - lvl));
      tree_d[node] = ~touch_idx_i[IDX_W-1-lvl];
    end
  end

  // follow the node bits from the root down to a leaf
  always_comb begin : victim_walk
    int unsigned node;
    node         = 0;
    victim_idx_o = '0;
    for (int unsigned lvl = 0; lvl < IDX_W; lvl++) begin
      victim_idx_o[IDX_W-1-lvl] = tree_q[node];
      node = 2 * node + 1 + tree_q[node];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (touch_i) begin
      tree_q <= tree_d;
    end
  end

endmodule

/* tlb/tlb_array.sv */
// ----------------------------------------------------------
// fully associative data TLB entries with tag match,
// superpage handling, flush and refill
// ----------------------------------------------------------

module tlb_array
  import sv39_pkg::*;
#(
  parameter int unsigned TLB_ENTRIES = sv39_pkg::TLB_ENTRIES
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lu_access_i,
  input  logic [VLEN-1:0]   lu_vaddr_i,
  input  logic [ASID_W-1:0] lu_asid_i,
  input  tlb_update_t       update_i,
  input  tlb_flush_t        flush_i,
  output tlb_lookup_t       lookup_o
);

  localparam int unsigned IDX_W = $clog2(TLB_ENTRIES);

  // tag part of an entry, valid bits are kept apart
  typedef struct packed {
    logic              is_2m;
    logic              is_1g;
    logic [ASID_W-1:0] asid;
    logic [VPN_W-1:0]  vpn;
  } tag_t;

  logic [TLB_ENTRIES-1:0] valid_q;
  tag_t                   tag_q     [TLB_ENTRIES];
  pte_t                   content_q [TLB_ENTRIES];

  logic [VPN_W-1:0]       lu_vpn;
  logic [VPN_W-1:0]       fl_vpn;
  logic [TLB_ENTRIES-1:0] hit_vec;
  logic [TLB_ENTRIES-1:0] flush_vec;
  logic [IDX_W-1:0]       hit_idx;
  logic [IDX_W-1:0]       free_idx;
  logic                   free_found;
  logic [IDX_W-1:0]       victim_idx;
  logic [IDX_W-1:0]       repl_idx;
  logic                   plru_touch;
  logic [IDX_W-1:0]       plru_idx;

  // page compare, superpages ignore the lower vpn fields
  function automatic logic page_match(tag_t tag, logic [VPN_W-1:0] vpn);
    logic vpn2_eq;
    logic vpn1_eq;
    logic vpn0_eq;
    vpn2_eq = tag.vpn[2*VPN_FIELD_W +: VPN_FIELD_W] == vpn[2*VPN_FIELD_W +: VPN_FIELD_W];
    vpn1_eq = tag.vpn[VPN_FIELD_W +: VPN_FIELD_W] == vpn[VPN_FIELD_W +: VPN_FIELD_W];
    vpn0_eq = tag.vpn[0 +: VPN_FIELD_W] == vpn[0 +: VPN_FIELD_W];
    return vpn2_eq && (tag.is_1g || vpn1_eq) && (tag.is_1g || tag.is_2m || vpn0_eq);
  endfunction

  assign lu_vpn = lu_vaddr_i[PAGE_OFFSET_W +: VPN_W];
  assign fl_vpn = flush_i.vaddr[PAGE_OFFSET_W +: VPN_W];

  // ----------------------------------------------------------
  // lookup and flush match
  // ----------------------------------------------------------
  always_comb begin : entry_match
    logic asid_hit;
    logic addr_hit;
    asid_hit = 1'b0;
    addr_hit = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // global pages match any address space
      hit_vec[i] = valid_q[i] && page_match(tag_q[i], lu_vpn) &&
                   (tag_q[i].asid == lu_asid_i || content_q[i].g);
      // flush never removes global pages when an asid is named
      asid_hit = (tag_q[i].asid == flush_i.asid) && !content_q[i].g;
      addr_hit = page_match(tag_q[i], fl_vpn);
      flush_vec[i] = flush_i.valid &&
                     (flush_i.asid == '0 || asid_hit) &&
                     (flush_i.vaddr == '0 || addr_hit);
    end
  end

  // lowest matching entry drives the result
  always_comb begin : lookup_mux
    lookup_o = '0;
    hit_idx  = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        lookup_o.hit     = 1'b1;
        lookup_o.is_2m   = tag_q[i].is_2m;
        lookup_o.is_1g   = tag_q[i].is_1g;
        lookup_o.content = content_q[i];
        hit_idx          = IDX_W'(i);
      end
    end
  end

  // ----------------------------------------------------------
  // refill slot and replacement
  // ----------------------------------------------------------
  always_comb begin : refill_select
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
    end
  end

  // an invalid slot is used before evicting anything
  assign repl_idx = free_found ? free_idx : victim_idx;

  // refill wins over a lookup hit in the same cycle
  assign plru_touch = update_i.valid || (lu_access_i && lookup_o.hit);
  assign plru_idx   = update_i.valid ? repl_idx : hit_idx;

  tlb_plru #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) plru_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .touch_i     (plru_touch),
    .touch_idx_i (plru_idx),
    .victim_idx_o(victim_idx)
  );

  // flush clears first, a refill on the same edge still lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_q & ~flush_vec;
      if (update_i.valid) begin
        valid_q[repl_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      tag_q[repl_idx].is_2m <= update_i.is_2m;
      tag_q[repl_idx].is_1g <= update_i.is_1g;
      tag_q[repl_idx].asid  <= update_i.asid;
      tag_q[repl_idx].vpn   <= update_i.vpn;
      content_q[repl_idx]   <= update_i.content;
    end
  end

endmodule

/* source/lsu_xlate_stage.sv */
// ----------------------------------------------------------
// data translation stage, cycle-0 hit and ppn, cycle-1
// physical address, page-fault checks and miss pulse
// ----------------------------------------------------------

module lsu_xlate_stage
  import sv39_pkg::*;
  import lsu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_translation_i,
  input  priv_lvl_e       priv_lvl_i,
  input  logic            sum_i,
  input  lsu_req_t        lsu_req_i,
  input  tlb_lookup_t     lookup_i,
  output logic            lu_access_o,
  output logic            lsu_dtlb_hit_o,
  output logic [PPNW-1:0] lsu_dtlb_ppn_o,
  output lsu_resp_t       lsu_resp_o,
  output logic            dtlb_miss_o
);

  logic [PLEN-1:0] vaddr_ext;
  logic [PLEN-1:0] vaddr_ext_q;

  // cycle-1 state
  logic            req_valid_q;
  logic [VLEN-1:0] vaddr_q;
  logic            is_store_q;
  tlb_lookup_t     lookup_q;

  logic            perm_err;
  logic [xlen-1:0] tval;
  pte_t            pte_q;

  // replace the low ppn bits by vaddr bits on superpages
  function automatic logic [PPNW-1:0] merge_ppn(logic [PPNW-1:0] ppn,
                                                logic [VLEN-1:0] vaddr,
                                                logic            is_2m,
                                                logic            is_1g);
    logic [PPNW-1:0] merged;
    merged = ppn;
    if (is_2m) begin
      merged[VPN_FIELD_W-1:0] = vaddr[PAGE_OFFSET_W +: VPN_FIELD_W];
    end
    if (is_1g) begin
      merged[2*VPN_FIELD_W-1:0] = vaddr[PAGE_OFFSET_W +: 2*VPN_FIELD_W];
    end
    return merged;
  endfunction

  // ----------------------------------------------------------
  // cycle 0
  // ----------------------------------------------------------
  // bare mode address, zero extended to PLEN
  assign vaddr_ext = PLEN'(lsu_req_i.vaddr);

  // replacement state only tracks translated requests
  assign lu_access_o = lsu_req_i.valid && en_translation_i;

  // translation off always hits
  assign lsu_dtlb_hit_o = en_translation_i ? lookup_i.hit : 1'b1;

  assign lsu_dtlb_ppn_o = en_translation_i ?
                          merge_ppn(lookup_i.content.ppn, lsu_req_i.vaddr,
                                    lookup_i.is_2m, lookup_i.is_1g) :
                          vaddr_ext[PLEN-1:PAGE_OFFSET_W];

  // ----------------------------------------------------------
  // stage register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= lsu_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_req_i.vaddr;
    is_store_q <= lsu_req_i.is_store;
    lookup_q   <= lookup_i;
  end

  // ----------------------------------------------------------
  // cycle 1
  // ----------------------------------------------------------
  assign pte_q       = lookup_q.content;
  assign vaddr_ext_q = PLEN'(vaddr_q);

  // tval carries the sign extended virtual address
  assign tval = {{(xlen - VLEN){vaddr_q[VLEN-1]}}, vaddr_q};

  // supervisor may touch user pages only with SUM set
  // user may touch only user pages
  assign perm_err = en_translation_i &&
                    ((priv_lvl_i == PRIV_S && !sum_i && pte_q.u) ||
                     (priv_lvl_i == PRIV_U && !pte_q.u));

  always_comb begin : resp_build
    lsu_resp_o  = '0;
    dtlb_miss_o = 1'b0;
    if (!en_translation_i) begin
      // bare mode, pass the address through
      lsu_resp_o.valid = req_valid_q;
      lsu_resp_o.paddr = vaddr_ext_q;
    end else begin
      lsu_resp_o.paddr = {merge_ppn(pte_q.ppn, vaddr_q, lookup_q.is_2m, lookup_q.is_1g),
                          vaddr_q[PAGE_OFFSET_W-1:0]};
      if (req_valid_q && lookup_q.hit) begin
        lsu_resp_o.valid = 1'b1;
        if (is_store_q) begin
          // stores need a writable page with the dirty bit already set
          if (!pte_q.w || !pte_q.d || perm_err) begin
            lsu_resp_o.ex.cause = STORE_PAGE_FAULT;
            lsu_resp_o.ex.tval  = tval;
            lsu_resp_o.ex.valid = 1'b1;
          end
        end else if (perm_err) begin
          lsu_resp_o.ex.cause = LOAD_PAGE_FAULT;
          lsu_resp_o.ex.tval  = tval;
          lsu_resp_o.ex.valid = 1'b1;
        end
      end else begin
        // no response on a miss, the requester refills and retries
        dtlb_miss_o = req_valid_q;
      end
    end
  end

endmodule

/* source/data_mmu.sv */
// ----------------------------------------------------------
// data-side Sv39 MMU top, TLB array and translation stage
// ----------------------------------------------------------

module data_mmu
  import sv39_pkg::*;
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_translation_i,
  input  priv_lvl_e         priv_lvl_i,
  input  logic              sum_i,
  input  logic [ASID_W-1:0] asid_i,
  input  lsu_req_t          lsu_req_i,
  output logic              lsu_dtlb_hit_o,
  output logic [PPNW-1:0]   lsu_dtlb_ppn_o,
  output lsu_resp_t         lsu_resp_o,
  output logic              dtlb_miss_o,
  input  tlb_update_t       update_i,
  input  tlb_flush_t        flush_i
);

  // combinational lookup from the cycle-0 address
  tlb_lookup_t lookup;
  logic        lu_access;

  tlb_array #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) tlb_array_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lu_access_i(lu_access),
    .lu_vaddr_i (lsu_req_i.vaddr),
    .lu_asid_i  (asid_i),
    .update_i   (update_i),
    .flush_i    (flush_i),
    .lookup_o   (lookup)
  );

  lsu_xlate_stage xlate_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_translation_i(en_translation_i),
    .priv_lvl_i      (priv_lvl_i),
    .sum_i           (sum_i),
    .lsu_req_i       (lsu_req_i),
    .lookup_i        (lookup),
    .lu_access_o     (lu_access),
    .lsu_dtlb_hit_o  (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o  (lsu_dtlb_ppn_o),
    .lsu_resp_o      (lsu_resp_o),
    .dtlb_miss_o     (dtlb_miss_o)
  );

endmodule

/* dv/tlb_model.svh */
// ----------------------------------------------------------
// reference model of the TLB entries, the pseudo-LRU tree
// and the page-fault rules
// ----------------------------------------------------------
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

localparam int IDX_W = $clog2(TLB_ENTRIES);

// an entry is kept as the refill that wrote it, valid marks it live
tlb_update_t            ent [TLB_ENTRIES];
logic [TLB_ENTRIES-2:0] plru_tree;

function automatic void clear_model();
  foreach (ent[i]) ent[i] = '0;
  plru_tree = '0;
endfunction

// vpn1 is ignored on 1 GiB pages, vpn0 on any superpage
function automatic logic page_hits(tlb_update_t e, logic [VPN_W-1:0] vpn);
  return e.vpn[26:18] == vpn[26:18] &&
         (e.is_1g || e.vpn[17:9] == vpn[17:9]) &&
         (e.is_1g || e.is_2m || e.vpn[8:0] == vpn[8:0]);
endfunction

// lowest matching entry, -1 on a miss
function automatic int find_entry(logic [VLEN-1:0] vaddr, logic [ASID_W-1:0] asid_v);
  for (int i = 0; i < TLB_ENTRIES; i++) begin
    if (ent[i].valid && page_hits(ent[i], vaddr[38:12]) &&
        (ent[i].asid == asid_v || ent[i].content.g)) begin
      return i;
    end
  end
  return -1;
endfunction

// point every node on the path away from the touched entry
function automatic void touch_tree(int idx);
  int node;
  int b;
  node = 0;
  for (int lvl = 0; lvl < IDX_W; lvl++) begin
    b = (idx >> (IDX_W - 1 - lvl)) & 1;
    plru_tree[node] = (b == 0);
    node = 2 * node + 1 + b;
  end
endfunction

// 0 goes left, starting at the root
function automatic int tree_victim();
  int node;
  int v;
  node = 0;
  v = 0;
  for (int lvl = 0; lvl < IDX_W; lvl++) begin
    v = 2 * v + plru_tree[node];
    node = 2 * node + 1 + plru_tree[node];
  end
  return v;
endfunction

function automatic void refill_entry(tlb_update_t upd);
  int slot;
  slot = -1;
  // lowest free slot first, else the tree victim
  for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
    if (!ent[i].valid) slot = i;
  end
  if (slot < 0) slot = tree_victim();
  ent[slot] = upd;
  touch_tree(slot);
endfunction

// zero asid or zero vaddr widens the flush, named asids spare global pages
function automatic void flush_entries(tlb_flush_t f);
  logic asid_ok;
  logic addr_ok;
  for (int i = 0; i < TLB_ENTRIES; i++) begin
    asid_ok = f.asid == '0 || (ent[i].asid == f.asid && !ent[i].content.g);
    addr_ok = f.vaddr == '0 || page_hits(ent[i], f.vaddr[38:12]);
    if (asid_ok && addr_ok) ent[i].valid = 1'b0;
  end
endfunction

// page number with the vaddr bits that a superpage passes through
function automatic logic [PPNW-1:0] compose_ppn(tlb_update_t e, logic [VLEN-1:0] vaddr);
  logic [PPNW-1:0] ppn;
  ppn = e.content.ppn;
  if (e.is_2m) ppn[8:0] = vaddr[20:12];
  if (e.is_1g) ppn[17:0] = vaddr[29:12];
  return ppn;
endfunction

// 0 means no fault, else the cause code
function automatic int fault_cause(pte_t pte, logic is_store, priv_lvl_e priv, logic sum_v);
  logic perm;
  perm = (priv == PRIV_S && !sum_v && pte.u) || (priv == PRIV_U && !pte.u);
  if (is_store && (!pte.w || !pte.d || perm)) return 15;
  if (!is_store && perm) return 13;
  return 0;
endfunction

`endif

/* dv/data_mmu_tb.sv */
// ----------------------------------------------------------
// data MMU testbench with random translation, fault, flush
// and eviction traffic against the TLB model
// ----------------------------------------------------------

module data_mmu_tb;
  import sv39_pkg::*;
  import lsu_pkg::*;

  localparam int TIMEOUT = 20;

  logic              clk_i;
  logic              rst_ni;
  logic              en_translation;
  priv_lvl_e         priv_lvl;
  logic              sum_en;
  logic [ASID_W-1:0] cur_asid;
  lsu_req_t          lsu_req;
  logic              dtlb_hit;
  logic [PPNW-1:0]   dtlb_ppn;
  lsu_resp_t         lsu_resp;
  logic              dtlb_miss;
  tlb_update_t       update;
  tlb_flush_t        flush;

  integer            seed = 32'h2c53_8b4b;
  // pages refilled in the current phase
  tlb_update_t       page_list[$];
  logic [VLEN-1:0]   vaddr_list[$];

  `include "tlb_model.svh"

  data_mmu data_mmu_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_translation_i(en_translation),
    .priv_lvl_i      (priv_lvl),
    .sum_i           (sum_en),
    .asid_i          (cur_asid),
    .lsu_req_i       (lsu_req),
    .lsu_dtlb_hit_o  (dtlb_hit),
    .lsu_dtlb_ppn_o  (dtlb_ppn),
    .lsu_resp_o      (lsu_resp),
    .dtlb_miss_o     (dtlb_miss),
    .update_i        (update),
    .flush_i         (flush)
  );

  always #2 clk_i = ~clk_i;

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    assert (expected == actual) else begin
      $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------
  // one request with its cycle-0 and cycle-1 checks
  // ----------------------------------------------------------
  task automatic request(logic [VLEN-1:0] vaddr, logic is_store, logic en, priv_lvl_e priv,
                         logic sum_v, logic [ASID_W-1:0] asid_v, output logic hit);
    int          idx;
    int          cycles;
    int          cause;
    tlb_update_t e;
    idx = en ? find_entry(vaddr, asid_v) : -1;
    e   = (idx >= 0) ? ent[idx] : '0;
    hit = !en || idx >= 0;
    @(posedge clk_i);
    en_translation <= en;
    priv_lvl       <= priv;
    sum_en         <= sum_v;
    cur_asid       <= asid_v;
    lsu_req        <= '{valid: 1'b1, vaddr: vaddr, is_store: is_store};
    @(negedge clk_i);
    check_value("lsu_dtlb_hit_o", hit, dtlb_hit);
    if (hit) begin
      check_value("lsu_dtlb_ppn_o", en ? compose_ppn(e, vaddr) : PPNW'(vaddr[38:12]), dtlb_ppn);
    end
    // a translated hit moves the replacement tree on the next edge
    if (idx >= 0) touch_tree(idx);
    cycles = 0;
    do begin
      @(posedge clk_i);
      lsu_req <= '0;
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: no response and no miss after a request");
        $display("test failed");
        $fatal(1);
      end
    end while (!lsu_resp.valid && !dtlb_miss);
    check_value("response latency", 1, cycles);
    check_value("lsu_resp_o.valid", hit, lsu_resp.valid);
    check_value("dtlb_miss_o", !hit, dtlb_miss);
    if (hit) begin
      check_value("lsu_resp_o.paddr",
                  en ? {compose_ppn(e, vaddr), vaddr[11:0]} : PLEN'(vaddr), lsu_resp.paddr);
      cause = en ? fault_cause(e.content, is_store, priv, sum_v) : 0;
      check_value("lsu_resp_o.ex.valid", cause != 0, lsu_resp.ex.valid);
      if (cause != 0) begin
        check_value("lsu_resp_o.ex.cause", cause, lsu_resp.ex.cause);
        check_value("lsu_resp_o.ex.tval", 64'($signed(vaddr)), lsu_resp.ex.tval);
      end
    end
  endtask

  task automatic refill(tlb_update_t upd);
    @(posedge clk_i);
    update <= upd;
    refill_entry(upd);
    @(posedge clk_i);
    update <= '0;
  endtask

  task automatic flush_tlb(logic [ASID_W-1:0] asid_v, logic [VLEN-1:0] vaddr);
    tlb_flush_t f;
    f.valid = 1'b1;
    f.asid  = asid_v;
    f.vaddr = vaddr;
    @(posedge clk_i);
    flush <= f;
    flush_entries(f);
    @(posedge clk_i);
    flush <= '0;
  endtask

  // random 4K, 2M or 1G page where a quarter of them are global
  task automatic random_page(logic [ASID_W-1:0] asid_v, output tlb_update_t upd,
                             output logic [VLEN-1:0] vaddr);
    int kind;
    kind          = $unsigned($random(seed)) % 3;
    vaddr         = VLEN'({$random(seed), $random(seed)});
    upd           = '0;
    upd.valid     = 1'b1;
    upd.is_2m     = kind == 1;
    upd.is_1g     = kind == 2;
    upd.vpn       = vaddr[PAGE_OFFSET_W +: VPN_W];
    upd.asid      = asid_v;
    upd.content   = pte_t'({$random(seed), $random(seed)});
    upd.content.g = ($random(seed) & 3) == 0;
    // global pages carry a foreign asid
    if (upd.content.g) upd.asid = ~asid_v;
  endtask

  function automatic priv_lvl_e random_priv();
    case ($unsigned($random(seed)) % 3)
      0:       return PRIV_U;
      1:       return PRIV_S;
      default: return PRIV_M;
    endcase
  endfunction

  // look up every page of the phase under its own asid
  task automatic probe_pages();
    logic hit;
    foreach (page_list[i]) begin
      request(vaddr_list[i], 1'b0, 1'b1, PRIV_M, 1'b0, page_list[i].asid, hit);
    end
  endtask

  initial begin
    tlb_update_t       upd;
    logic [VLEN-1:0]   va;
    logic [VLEN-1:0]   mask;
    logic [ASID_W-1:0] asid_v;
    priv_lvl_e         priv;
    logic              store;
    logic              sum_v;
    logic              hit;
    int                idx;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    en_translation = 1'b0;
    priv_lvl       = PRIV_S;
    sum_en         = 1'b0;
    cur_asid       = '0;
    lsu_req        = '0;
    update         = '0;
    flush          = '0;
    clear_model();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // ----------------------------------------------------------
    // translation off
    // ----------------------------------------------------------
    repeat (8) begin
      request(VLEN'({$random(seed), $random(seed)}), $random(seed), 1'b0, random_priv(),
              $random(seed), ASID_W'($random(seed)), hit);
    end

    // random pages that miss, get refilled and then hit under random permissions
    repeat (40) begin
      asid_v = ASID_W'(1 + $unsigned($random(seed)) % 4);
      random_page(asid_v, upd, va);
      priv  = random_priv();
      store = $random(seed);
      sum_v = $random(seed);
      request(va, store, 1'b1, priv, sum_v, asid_v, hit);
      if (!hit) begin
        refill(upd);
        request(va, store, 1'b1, priv, sum_v, asid_v, hit);
      end
      // another offset inside the same page
      mask = upd.is_1g ? 39'h3fff_ffff : (upd.is_2m ? 39'h1f_ffff : 39'hfff);
      va   = (va & ~mask) | (VLEN'($random(seed)) & mask);
      request(va, $random(seed), 1'b1, random_priv(), $random(seed), asid_v, hit);
    end

    // ----------------------------------------------------------
    // flush with asid and vaddr each zero or named
    // ----------------------------------------------------------
    for (int combo = 0; combo < 4; combo++) begin
      flush_tlb('0, '0);
      page_list.delete();
      vaddr_list.delete();
      for (int n = 0; n < TLB_ENTRIES; n++) begin
        random_page(ASID_W'(1 + n % 2), upd, va);
        refill(upd);
        page_list.push_back(upd);
        vaddr_list.push_back(va);
      end
      flush_tlb(combo[1] ? ASID_W'(1) : '0, combo[0] ? vaddr_list[0] : '0);
      probe_pages();
    end

    // eviction by more 4K pages than entries with lookups in between
    flush_tlb('0, '0);
    page_list.delete();
    vaddr_list.delete();
    for (int n = 0; n < TLB_ENTRIES + 2; n++) begin
      random_page(ASID_W'(1), upd, va);
      upd.is_2m     = 1'b0;
      upd.is_1g     = 1'b0;
      upd.content.g = 1'b0;
      upd.asid      = ASID_W'(1);
      refill(upd);
      page_list.push_back(upd);
      vaddr_list.push_back(va);
      idx = $unsigned($random(seed)) % page_list.size();
      request(vaddr_list[idx], 1'b0, 1'b1, PRIV_M, 1'b0, ASID_W'(1), hit);
    end
    probe_pages();

    $display("test passed");
    $finish;
  end

endmodule

/* data_mmu.f */
+incdir+dv
common/sv39_pkg.sv
common/lsu_pkg.sv
tlb/tlb_plru.sv
tlb/tlb_array.sv
source/lsu_xlate_stage.sv
source/data_mmu.sv
dv/data_mmu_tb.sv
